/* cpu_trace.txt */
# kind addr bytes: P preloads memory, W expected writes in order, M expected final memory
# several bytes on one line go to consecutive addresses starting at addr
P 00000 B0 12 A2 00 00 B8 34 12 A3 02 00 04 F0 14 01 2C
P 00010 30 1C 01 A3 04 00 0D 0F 00 25 F0 0F 35 FF 00 A3
P 00020 06 00 3D 0F 02 75 03 A2 08 00 3C 10 73 03 A2 09
P 00030 00 72 03 A2 0A 00 BB FF FF 43 4B 4B 53 41 4A F9
P 00040 73 01 51 F8 73 01 52 F5 72 01 52 F5 72 01 52 5E
P 00050 5F 57 A1 10 00 A3 12 00 EB 04 A3 14 00 F4 3C 78
P 00060 70 01 55 72 01 55 74 01 55 76 01 55 78 01 55 7A
P 00070 01 55 7C 01 55 7E 01 55 EB E0
P 10010 78 56
W 10000 12
W 10002 34 12
W 10004 F4 12
W 10006 0F 02
W 10008 0F
W 10009 0F
W 200FE FE FF
W 200FC 01 00
W 200FA FF FF
W 200FC 01 00
W 10012 78 56
W 200FA 00 00
W 200F8 00 00
W 200F6 00 00
W 200F4 00 00
W 10014 78 56
M 10000 12 00 34 12 F4 12 0F 02 0F 0F 00
M 10010 78 56 78 56 78 56
M 200F4 00 00 00 00 00 00 00 00 01 00 FE FF

/* tb.f */
+incdir+.
cpu_pkg.sv
mem_req_if.sv
reg_file.sv
alu.sv
bus_arbiter.sv
data_port.sv
exec_core.sv
cpu_top.sv
cpu_assertions.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

/* tb_top.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module tb_top;

    logic               clk;
    logic               i_rst_n;
    logic [7:0]         i_data;
    logic [`ADDR_W-1:0] o_addr;
    logic [7:0]         o_data;
    logic               o_write;
    logic               o_halt;

    logic [7:0] mem [0:(1 << `ADDR_W) - 1];
    int         exp_addr [256];
    int         exp_data [256];
    int         exp_n;
    int         fin_addr [64];
    int         fin_data [64];
    int         fin_n;
    int         toks [$];
    int         prog_bytes;
    int         limit;
    int         errors;
    int         writes_seen;
    logic       load_ok;
    logic       final_req;
    logic       final_done;
    logic       timed_out;

    cpu_top i_dut (
        .clk,
        .i_rst_n,
        .i_data,
        .o_addr,
        .o_data,
        .o_write,
        .o_halt
    );

    tb_checker u_chk (
        .clk, .i_rst_n, .o_addr, .o_data, .o_write, .o_halt,
        .i_limit(limit), .i_final(final_req), .o_timed_out(timed_out),
        .o_final_done(final_done), .o_errors(errors), .o_writes(writes_seen)
    );

    // Memory answers in the same cycle
    assign i_data = mem[o_addr];

    // Writes land on the falling edge
    always @(negedge clk) begin
        if (o_write)
            mem[o_addr] = o_data;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int hex_digit(byte c);
        if (c >= 8'h30 && c <= 8'h39)
            return c - 8'h30;
        if (c >= 8'h41 && c <= 8'h46)
            return c - 8'h41 + 10;
        if (c >= 8'h61 && c <= 8'h66)
            return c - 8'h61 + 10;
        return -1;
    endfunction

    // Hex tokens after the kind letter
    task automatic split_hex(input string line);
        int val;
        int d;
        bit in_tok;
        toks.delete();
        val = 0;
        in_tok = 1'b0;
        for (int i = 1; i < line.len(); i++) begin
            d = hex_digit(line.getc(i));
            if (d >= 0) begin
                val = val * 16 + d;
                in_tok = 1'b1;
            end else if (in_tok) begin
                toks.push_back(val);
                val = 0;
                in_tok = 1'b0;
            end
        end
        if (in_tok)
            toks.push_back(val);
    endtask

    task automatic load_trace(output logic ok);
        int    fd;
        int    code;
        string line;
        byte   kind;
        ok = 1'b0;
        fd = $fopen("cpu_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    kind = line.getc(0);
                    split_hex(line);
                    for (int k = 1; k < toks.size(); k++) begin
                        if (kind == 8'h50) begin
                            mem[toks[0] + k - 1] = toks[k][7:0];
                            prog_bytes++;
                        end else if (kind == 8'h57) begin
                            exp_addr[exp_n] = toks[0] + k - 1;
                            exp_data[exp_n] = toks[k];
                            exp_n++;
                        end else if (kind == 8'h4D) begin
                            fin_addr[fin_n] = toks[0] + k - 1;
                            fin_data[fin_n] = toks[k];
                            fin_n++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        final_req  = 1'b0;
        limit      = 0;
        exp_n      = 0;
        fin_n      = 0;
        prog_bytes = 0;
        for (int a = 0; a < (1 << `ADDR_W); a++)
            mem[a] = 8'h00;
        load_trace(load_ok);
        if (!load_ok) begin
            $display("Trace file cpu_trace.txt could not be opened");
            $display("Result: FAILED");
            $finish;
        end else begin
            limit = prog_bytes * 20 + 200;
            repeat (4) @(negedge clk);
            i_rst_n = 1'b1;
            while (!o_halt && !timed_out)
                @(negedge clk);
            // Idle cycles after halt where any write is an error
            repeat (8) @(negedge clk);
            final_req = 1'b1;
            while (!final_done)
                @(negedge clk);
            $display("Errors: %0d, writes %0d of %0d", errors, writes_seen, exp_n);
            if (errors == 0 && !timed_out) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

module tb_checker (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic [19:0] o_addr,
    input  logic [7:0]  o_data,
    input  logic        o_write,
    input  logic        o_halt,
    input  int          i_limit,
    input  logic        i_final,
    output logic        o_timed_out,
    output logic        o_final_done,
    output int          o_errors,
    output int          o_writes
);

    int w_idx;
    int err_w;
    int err_f;
    int cycles;

    initial begin
        w_idx        = 0;
        err_w        = 0;
        err_f        = 0;
        cycles       = 0;
        o_timed_out  = 1'b0;
        o_final_done = 1'b0;
    end

    assign o_errors = err_w + err_f;
    assign o_writes = w_idx;

    // ----------------------------------------
    // Write stream sampled mid-cycle
    always @(negedge clk) begin
        if (i_rst_n && o_write) begin
            if (o_halt) begin
                err_w++;
                $display("A write happened after the core halted");
            end
            if (w_idx >= tb_top.exp_n) begin
                err_w++;
                $display("Write at address %h is more than the trace expects", o_addr);
            end else begin
                if (o_addr !== tb_top.exp_addr[w_idx][19:0]) begin
                    err_w++;
                    $display("[FAIL] o_addr: got %h expected %h",
                             o_addr, tb_top.exp_addr[w_idx][19:0]);
                end
                if (o_data !== tb_top.exp_data[w_idx][7:0]) begin
                    err_w++;
                    $display("[FAIL] o_data: got %h expected %h",
                             o_data, tb_top.exp_data[w_idx][7:0]);
                end
                w_idx++;
            end
        end
    end

    // ----------------------------------------
    // Timeout and final memory
    always @(posedge clk) begin
        if (i_rst_n && !o_halt && !o_timed_out && i_limit > 0) begin
            cycles++;
            if (cycles >= i_limit) begin
                o_timed_out = 1'b1;
                err_f++;
                $display("Timeout: core did not halt within %0d cycles", i_limit);
            end
        end
        if (i_final && !o_final_done) begin
            if (o_halt !== 1'b1) begin
                err_f++;
                $display("The core is not halted at the end of the run");
            end
            if (w_idx != tb_top.exp_n) begin
                err_f++;
                $display("Saw %0d writes but the trace expects %0d", w_idx, tb_top.exp_n);
            end
            for (int i = 0; i < tb_top.fin_n; i++) begin
                if (tb_top.mem[tb_top.fin_addr[i]] !== tb_top.fin_data[i][7:0]) begin
                    err_f++;
                    $display("[FAIL] mem[%h]: got %h expected %h", tb_top.fin_addr[i][19:0],
                             tb_top.mem[tb_top.fin_addr[i]], tb_top.fin_data[i][7:0]);
                end
            end
            o_final_done = 1'b1;
        end
    end

endmodule

/* cpu_assertions.sv */
`timescale 1ns/100ps

module cpu_assertions (
    input logic clk,
    input logic i_rst_n,
    input logic i_code_req,
    input logic i_data_req,
    input logic i_data_grant,
    input logic i_write,
    input logic i_halt
);

    // A data transfer holds the port for one or two bytes
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     i_data_grant ##1 i_data_grant |=> !i_data_grant)
        else $error("Data side held the port for more than two cycles");

    assert property (@(posedge clk) !i_rst_n |-> !i_write)
        else $error("Memory write during reset");

    // A halted core leaves the bus idle
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     i_halt |-> !(i_code_req || i_data_req))
        else $error("Bus request after halt");

endmodule

bind cpu_top cpu_assertions u_assert (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_code_req   (code_bus.req),
    .i_data_req   (data_bus.req),
    .i_data_grant (data_bus.grant),
    .i_write      (o_write),
    .i_halt       (o_halt)
);

/* cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_top (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [7:0]         i_data,
    output logic [`ADDR_W-1:0] o_addr,
    output logic [7:0]         o_data,
    output logic               o_write,
    output logic               o_halt
);

    mem_req_if code_bus ();
    mem_req_if data_bus ();
    xfer_if    xfer ();

    exec_core u_core (
        .clk,
        .i_rst_n,
        .code   (code_bus),
        .xfer   (xfer),
        .o_halt
    );

    // Stack and direct-address data, one byte per cycle
    data_port u_dport (
        .clk,
        .i_rst_n,
        .xfer   (xfer),
        .mem    (data_bus)
    );

    bus_arbiter u_arb (
        .clk,
        .i_rst_n,
        .code   (code_bus),
        .data   (data_bus),
        .i_data,
        .o_addr,
        .o_data,
        .o_write
    );

endmodule

/* exec_core.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module exec_core import cpu_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,
    mem_req_if.requester code,
    xfer_if.core         xfer,
    output logic         o_halt
);

    localparam logic [2:0] S_FETCH  = 3'd0;
    localparam logic [2:0] S_IMM_LO = 3'd1;
    localparam logic [2:0] S_IMM_HI = 3'd2;
    localparam logic [2:0] S_XFER   = 3'd3;
    localparam logic [2:0] S_HALT   = 3'd4;

    logic [2:0]  state;
    logic [15:0] ip;
    logic [11:0] flags, alu_flags;
    opcode_u     op_q, cur;
    logic [7:0]  imm_lo_q;
    logic        is_alu, is_incdec, is_push, is_pop, is_jcc, is_jmp, is_movi, is_movm;
    logic        wide, two_imm, last_imm, cc, taken;
    logic [15:0] imm_val, rd_a, ax, sp, alu_res, wr_val;
    logic        wr_en, wr_wide;
    logic [2:0]  wr_idx, rd_idx;

    // ----------------------------------------
    // Decode, live byte during fetch, latched opcode after
    always_comb begin
        cur.raw   = (state == S_FETCH) ? code.rdata : op_q.raw;
        is_alu    = (cur.alu.cls == 2'b00) && (cur.alu.form[2:1] == 2'b10);
        is_incdec = (cur.rg.group[4:1] == 4'b0100);
        is_push   = (cur.rg.group == 5'b01010);
        is_pop    = (cur.rg.group == 5'b01011);
        is_movm   = (cur.rg.group == 5'b10100) && !cur.rg.reg_idx[2];
        is_jcc    = (cur.jcc.group == 4'h7);
        is_movi   = (cur.jcc.group == 4'hB);
        is_jmp    = (cur.raw == `OP_JMP8);
        if (is_movi)
            wide = cur.raw[3];
        else if (is_alu || is_movm)
            wide = cur.raw[0];
        else
            wide = 1'b1;
        // Direct address is always two bytes
        two_imm  = is_movm || ((is_alu || is_movi) && wide);
        last_imm = (state == S_IMM_HI) || (state == S_IMM_LO && !two_imm);
        imm_val  = wide ? {code.rdata, imm_lo_q} : {8'h00, code.rdata};
        rd_idx   = (is_incdec || is_push) ? cur.rg.reg_idx : 3'd0;
    end

    // Jcc pairs, odd code is the negated test
    always_comb begin
        case (cur.jcc.cond[3:1])
            3'd0:    cc = flags[`FLAG_O];
            3'd1:    cc = flags[`FLAG_C];
            3'd2:    cc = flags[`FLAG_Z];
            3'd3:    cc = flags[`FLAG_C] | flags[`FLAG_Z];
            3'd4:    cc = flags[`FLAG_S];
            3'd5:    cc = flags[`FLAG_P];
            3'd6:    cc = flags[`FLAG_S] ^ flags[`FLAG_O];
            default: cc = (flags[`FLAG_S] ^ flags[`FLAG_O]) | flags[`FLAG_Z];
        endcase
        taken = is_jmp || (is_jcc && (cc ^ cur.jcc.cond[0]));
    end

    // Single register write port
    always_comb begin
        wr_en   = 1'b0;
        wr_wide = wide;
        wr_idx  = cur.rg.reg_idx;
        wr_val  = alu_res;
        case (state)
            S_FETCH: begin
                if (code.grant && is_incdec) begin
                    wr_en = 1'b1;
                end else if (code.grant && (is_push || is_pop)) begin
                    wr_en  = 1'b1;
                    wr_idx = 3'd4;
                    wr_val = is_push ? sp - 16'd2 : sp + 16'd2;
                end
            end
            S_IMM_LO, S_IMM_HI: begin
                if (code.grant && last_imm && is_movi) begin
                    wr_en  = 1'b1;
                    wr_val = imm_val;
                end else if (code.grant && last_imm && is_alu &&
                             cur.alu.alu_op != `ALU_CMP) begin
                    wr_en  = 1'b1;
                    wr_idx = 3'd0;
                end
            end
            S_XFER: begin
                if (xfer.done && !xfer.write) begin
                    wr_en  = 1'b1;
                    wr_idx = is_pop ? cur.rg.reg_idx : 3'd0;
                    wr_val = xfer.rdata16;
                end
            end
            default: wr_en = 1'b0;
        endcase
    end

    reg_file u_regs (
        .clk, .i_rst_n,
        .i_wr_en(wr_en), .i_wr_wide(wr_wide), .i_wr_idx(wr_idx), .i_wr_val(wr_val),
        .i_rd_idx_a(rd_idx), .i_rd_wide_a(wide), .o_rd_a(rd_a),
        .o_ax(ax), .o_sp(sp)
    );

    alu u_alu (
        .i_op(cur), .i_wide(wide), .i_a(rd_a),
        .i_b(is_incdec ? 16'h0001 : imm_val),
        .i_flags(flags), .o_result(alu_res), .o_flags(alu_flags)
    );

    // ----------------------------------------
    // Code fetch and data transfer requests
    assign code.req   = (state == S_FETCH) || (state == S_IMM_LO) || (state == S_IMM_HI);
    assign code.addr  = {`CS_BASE, 4'h0} + {4'h0, ip};
    assign code.wdata = 8'h00;
    assign code.write = 1'b0;

    assign xfer.start     = code.grant && (((state == S_FETCH) && (is_push || is_pop)) ||
                                           ((state == S_IMM_HI) && is_movm));
    assign xfer.write     = is_push || (is_movm && cur.raw[1]);
    assign xfer.wide      = wide;
    assign xfer.stack_sel = is_push || is_pop;
    assign xfer.offset    = is_push ? sp - 16'd2 : (is_pop ? sp : {code.rdata, imm_lo_q});
    assign xfer.wdata16   = is_push ? rd_a : ax;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state  <= S_FETCH;
            ip     <= 16'h0000;
            flags  <= 12'h002;
            o_halt <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (code.grant) begin
                        ip <= ip + 16'd1;
                        if (cur.raw == `OP_HLT) begin
                            o_halt <= 1'b1;
                            state  <= S_HALT;
                        end else if (is_alu || is_movi || is_movm || is_jcc || is_jmp) begin
                            state <= S_IMM_LO;
                        end else if (is_push || is_pop) begin
                            state <= S_XFER;
                        end
                        case (cur.raw)
                            `OP_CLC: flags[`FLAG_C] <= 1'b0;
                            `OP_STC: flags[`FLAG_C] <= 1'b1;
                            `OP_CMC: flags[`FLAG_C] <= ~flags[`FLAG_C];
                            default: if (is_incdec) flags <= alu_flags;
                        endcase
                    end
                end
                S_IMM_LO, S_IMM_HI: begin
                    if (code.grant) begin
                        // Displacement is relative to the next instruction
                        if (taken)
                            ip <= ip + 16'd1 + {{8{code.rdata[7]}}, code.rdata};
                        else
                            ip <= ip + 16'd1;
                        if (!last_imm)
                            state <= S_IMM_HI;
                        else if (is_movm)
                            state <= S_XFER;
                        else
                            state <= S_FETCH;
                        if (is_alu && last_imm)
                            flags <= alu_flags;
                    end
                end
                S_XFER: begin
                    if (xfer.done)
                        state <= S_FETCH;
                end
                default: state <= S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && code.grant)
            op_q <= cur;
        if (state == S_IMM_LO && code.grant)
            imm_lo_q <= code.rdata;
    end

endmodule

/* data_port.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module data_port (
    input  logic         clk,
    input  logic         i_rst_n,
    xfer_if.port         xfer,
    mem_req_if.requester mem
);

    logic        busy, hi_phase, last;
    logic        write_q, wide_q, stack_q;
    logic [15:0] offset_q, wdata_q, byte_off, seg;
    logic [7:0]  lo_q;

    // Low byte at offset, then high byte at offset + 1
    assign byte_off  = offset_q + {15'd0, hi_phase};
    assign seg       = stack_q ? `SS_BASE : `DS_BASE;
    assign mem.req   = busy;
    assign mem.addr  = {seg, 4'h0} + {4'h0, byte_off};
    assign mem.wdata = hi_phase ? wdata_q[15:8] : wdata_q[7:0];
    assign mem.write = busy & write_q;
    assign last      = busy & mem.grant & (hi_phase | ~wide_q);

    assign xfer.done    = last;
    assign xfer.rdata16 = wide_q ? {mem.rdata, lo_q} : {8'h00, mem.rdata};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            hi_phase <= 1'b0;
        end else if (xfer.start) begin
            busy     <= 1'b1;
            hi_phase <= 1'b0;
        end else if (busy && mem.grant) begin
            busy     <= ~last;
            hi_phase <= ~last;
        end
    end

    // Transfer fields and the first byte read
    always_ff @(posedge clk) begin
        if (xfer.start) begin
            write_q  <= xfer.write;
            wide_q   <= xfer.wide;
            stack_q  <= xfer.stack_sel;
            offset_q <= xfer.offset;
            wdata_q  <= xfer.wdata16;
        end
        if (busy && mem.grant && !hi_phase)
            lo_q <= mem.rdata;
    end

endmodule

/* bus_arbiter.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module bus_arbiter (
    input  logic               clk,
    input  logic               i_rst_n,
    mem_req_if.arbiter         code,
    mem_req_if.arbiter         data,
    input  logic [7:0]         i_data,
    output logic [`ADDR_W-1:0] o_addr,
    output logic [7:0]         o_data,
    output logic               o_write
);

    // Data side wins and code fetch stalls behind it
    assign data.grant = data.req;
    assign code.grant = code.req & ~data.req;

    assign o_addr  = data.req ? data.addr : code.addr;
    assign o_data  = data.req ? data.wdata : code.wdata;
    assign o_write = (data.grant & data.write) | (code.grant & code.write);

    // Same byte to both requesters
    assign data.rdata = i_data;
    assign code.rdata = i_data;

endmodule

/* alu.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module alu import cpu_pkg::*; (
    input  opcode_u     i_op,
    input  logic        i_wide,
    input  logic [15:0] i_a,
    input  logic [15:0] i_b,
    input  logic [11:0] i_flags,
    output logic [15:0] o_result,
    output logic [11:0] o_flags
);

    logic [2:0]  op;
    logic        incdec, cin, arith, is_sub;
    logic        a_msb, b_msb, r_msb;
    logic [15:0] a, b, res;
    logic [16:0] full;

    always_comb begin
        // INC runs as ADD and DEC as SUB, both with i_b = 1
        incdec = (i_op.rg.group[4:1] == 4'b0100);
        if (incdec)
            op = i_op.rg.group[0] ? 3'd5 : 3'd0;
        else
            op = i_op.alu.alu_op;
        a      = i_wide ? i_a : {8'h00, i_a[7:0]};
        b      = i_wide ? i_b : {8'h00, i_b[7:0]};
        cin    = (op == 3'd2 || op == 3'd3) && i_flags[`FLAG_C];
        is_sub = (op == 3'd3 || op == 3'd5 || op == `ALU_CMP);
        arith  = !(op == 3'd1 || op == 3'd4 || op == 3'd6);

        case (op)
            3'd0, 3'd2:            full = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
            3'd3, 3'd5, `ALU_CMP:  full = {1'b0, a} - {1'b0, b} - {16'h0000, cin};
            3'd1:                  full = {1'b0, a | b};
            3'd4:                  full = {1'b0, a & b};
            default:               full = {1'b0, a ^ b};
        endcase

        res   = i_wide ? full[15:0] : {8'h00, full[7:0]};
        a_msb = i_wide ? a[15] : a[7];
        b_msb = i_wide ? b[15] : b[7];
        r_msb = i_wide ? res[15] : res[7];

        // ----------------------------------------
        // Flags, logic ops clear CF OF AF
        o_flags            = i_flags;
        o_flags[`FLAG_S]   = r_msb;
        o_flags[`FLAG_Z]   = (res == 16'h0000);
        o_flags[`FLAG_P]   = ~^res[7:0];
        o_flags[`FLAG_A]   = arith & (a[4] ^ b[4] ^ res[4]);
        o_flags[`FLAG_O]   = arith & (is_sub ? (a_msb ^ b_msb) : ~(a_msb ^ b_msb))
                           & (r_msb ^ a_msb);
        // Carry or borrow out of the top bit, INC/DEC keep CF
        if (!incdec)
            o_flags[`FLAG_C] = arith & (i_wide ? full[16] : full[8]);
    end

    assign o_result = res;

endmodule

/* reg_file.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module reg_file (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_wr_en,
    input  logic        i_wr_wide,
    input  logic [2:0]  i_wr_idx,
    input  logic [15:0] i_wr_val,
    input  logic [2:0]  i_rd_idx_a,
    input  logic        i_rd_wide_a,
    output logic [15:0] o_rd_a,
    output logic [15:0] o_ax,
    output logic [15:0] o_sp
);

    // AX CX DX BX SP BP SI DI
    logic [15:0] regs [8];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= (i == 4) ? `SP_RESET : 16'h0000;
        end else if (i_wr_en) begin
            if (i_wr_wide)
                regs[i_wr_idx] <= i_wr_val;
            else if (i_wr_idx[2])
                regs[{1'b0, i_wr_idx[1:0]}][15:8] <= i_wr_val[7:0];
            else
                regs[{1'b0, i_wr_idx[1:0]}][7:0] <= i_wr_val[7:0];
        end
    end

    // Byte indices 4..7 are AH CH DH BH
    always_comb begin
        if (i_rd_wide_a)
            o_rd_a = regs[i_rd_idx_a];
        else if (i_rd_idx_a[2])
            o_rd_a = {8'h00, regs[{1'b0, i_rd_idx_a[1:0]}][15:8]};
        else
            o_rd_a = {8'h00, regs[{1'b0, i_rd_idx_a[1:0]}][7:0]};
    end

    assign o_ax = regs[0];
    assign o_sp = regs[4];

endmodule

/* mem_req_if.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

// One requester's byte access, moves when req and grant are both high
interface mem_req_if;
    logic                req;
    logic [`ADDR_W-1:0]  addr;
    logic [7:0]          wdata;
    logic                write;
    logic                grant;
    logic [7:0]          rdata;

    modport requester (output req, addr, wdata, write, input grant, rdata);
    modport arbiter   (input req, addr, wdata, write, output grant, rdata);
endinterface

// Core to data port, start pulse in, done pulse back
interface xfer_if;
    logic        start;
    logic        write;
    logic        wide;
    logic        stack_sel;
    logic [15:0] offset;
    logic [15:0] wdata16;
    logic [15:0] rdata16;
    logic        done;

    modport core (output start, write, wide, stack_sel, offset, wdata16,
                  input rdata16, done);
    modport port (input start, write, wide, stack_sel, offset, wdata16,
                  output rdata16, done);
endinterface

/* cpu_pkg.sv */
package cpu_pkg;

    // One opcode byte read through several decode views
    typedef union packed {
        logic [7:0] raw;
        // 00 ooo 10w: ALU on AL/AX with immediate
        struct packed {
            logic [1:0] cls;
            logic [2:0] alu_op;
            logic [2:0] form;
        } alu;
        // Register number in the low bits
        struct packed {
            logic [4:0] group;
            logic [2:0] reg_idx;
        } rg;
        // 0111 cccc, low bit inverts the condition
        struct packed {
            logic [3:0] group;
            logic [3:0] cond;
        } jcc;
    } opcode_u;

endpackage

/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Physical address, 1 MB space
`define ADDR_W      20

// Fixed segments, physical = seg * 16 + offset
`define CS_BASE     16'h0000
`define DS_BASE     16'h1000
`define SS_BASE     16'h2000
`define SP_RESET    16'h0100

// Bit positions in the 12-bit flags word
`define FLAG_C      0
`define FLAG_P      2
`define FLAG_A      4
`define FLAG_Z      6
`define FLAG_S      7
`define FLAG_O      11

// Opcodes matched as whole bytes
`define OP_HLT      8'hF4
`define OP_JMP8     8'hEB
`define OP_CLC      8'hF8
`define OP_STC      8'hF9
`define OP_CMC      8'hF5

// ALU code of CMP, result is dropped
`define ALU_CMP     3'd7

`endif
